/* hw/rv_exec_pkg.sv */
package rv_exec_pkg;

  localparam int xlen = 64;

  // major opcodes of the supported subset.
  typedef enum logic [6:0] {
    opc_op        = 7'b0110011,
    opc_op_imm    = 7'b0010011,
    opc_op_32     = 7'b0111011,
    opc_op_imm_32 = 7'b0011011,
    opc_lui       = 7'b0110111,
    opc_auipc     = 7'b0010111,
    opc_jal       = 7'b1101111,
    opc_branch    = 7'b1100011
  } rv_opcode_e;

  typedef enum logic [2:0] {
    addop,  // lui, auipc and plain sums.
    mop,
    mwop,
    riop,
    riwop,
    branch,
    none
  } alu_class_e;

  // apb register map.
  localparam logic [11:0] reg_instr    = 12'h000;
  localparam logic [11:0] reg_pc_lo    = 12'h008;
  localparam logic [11:0] reg_pc_hi    = 12'h00c;
  localparam logic [11:0] reg_br_count = 12'h010;
  localparam logic [11:0] reg_gpr_base = 12'h100;

  localparam logic [xlen-1:0] pc_reset = 64'h0000_0000_8000_0000;

endpackage

/* hw/alu.sv */
module alu
  import rv_exec_pkg::*;
(
  input  logic            add_pc_en,
  input  logic            add_rs1_en,
  input  logic            add_zero_en,
  input  logic            imm_en,
  input  logic            rs2_en,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] data_rs1,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] data_rs2,
  input  alu_class_e      alu_class,
  input  logic            funct7_5,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] alu_result,
  output logic            br_result
);

  logic [xlen-1:0]   op_a, op_b, sum;
  logic [5:0]        shamt;
  logic [2*xlen-1:0] mul_ss, mul_uu, mul_su;
  logic              div_zero, div_ovf;
  logic [xlen-1:0]   div_s, rem_s;
  logic [xlen-1:0]   m_div, m_divu, m_rem, m_remu, m_res;
  logic [31:0]       a_w, b_w, m2_w;
  logic              divw_zero, divw_ovf;
  logic [31:0]       divw_s, remw_s;
  logic [31:0]       mw_div, mw_divu, mw_rem, mw_remu, mw_res;
  logic [xlen-1:0]   ri_sra, ri_res;
  logic [31:0]       riw_sra, riw_res;
  logic              br_cond;

  function automatic logic [xlen-1:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // adder operand a is zero for lui, pc for auipc and rs1 otherwise.
  assign op_a  = add_zero_en ? '0 : add_pc_en ? pc : add_rs1_en ? data_rs1 : '0;
  assign op_b  = rs2_en ? data_rs2 : imm_en ? imm : '0;
  assign sum   = op_a + op_b;
  assign shamt = op_b[5:0];

  assign mul_ss = $signed(data_rs1) * $signed(data_rs2);
  assign mul_uu = data_rs1 * data_rs2;
  assign mul_su = {{xlen{data_rs1[xlen-1]}}, data_rs1} * {{xlen{1'b0}}, data_rs2};

  assign div_zero = data_rs2 == '0;
  assign div_ovf  = (data_rs1 == {1'b1, {(xlen-1){1'b0}}}) && (data_rs2 == '1);
  assign div_s    = $signed(data_rs1) / $signed(data_rs2);
  assign rem_s    = $signed(data_rs1) % $signed(data_rs2);
  assign m_div    = div_zero ? '1 : div_ovf ? data_rs1 : div_s;
  assign m_divu   = div_zero ? '1 : data_rs1 / data_rs2;
  assign m_rem    = div_zero ? data_rs1 : div_ovf ? '0 : rem_s;
  assign m_remu   = div_zero ? data_rs1 : data_rs1 % data_rs2;

  always_comb begin
    case (funct3)
      3'b000:  m_res = mul_ss[xlen-1:0];
      3'b001:  m_res = mul_ss[2*xlen-1:xlen];
      3'b010:  m_res = mul_su[2*xlen-1:xlen];
      3'b011:  m_res = mul_uu[2*xlen-1:xlen];
      3'b100:  m_res = m_div;
      3'b101:  m_res = m_divu;
      3'b110:  m_res = m_rem;
      default: m_res = m_remu;
    endcase
  end

  // word forms work on the low halves.
  assign a_w  = data_rs1[31:0];
  assign b_w  = op_b[31:0];
  assign m2_w = data_rs2[31:0];

  assign divw_zero = m2_w == 32'd0;
  assign divw_ovf  = (a_w == 32'h8000_0000) && (m2_w == 32'hffff_ffff);
  assign divw_s    = $signed(a_w) / $signed(m2_w);
  assign remw_s    = $signed(a_w) % $signed(m2_w);
  assign mw_div    = divw_zero ? '1 : divw_ovf ? a_w : divw_s;
  assign mw_divu   = divw_zero ? '1 : a_w / m2_w;
  assign mw_rem    = divw_zero ? a_w : divw_ovf ? '0 : remw_s;
  assign mw_remu   = divw_zero ? a_w : a_w % m2_w;

  always_comb begin
    case (funct3)
      3'b000:  mw_res = mul_ss[31:0];
      3'b100:  mw_res = mw_div;
      3'b101:  mw_res = mw_divu;
      3'b110:  mw_res = mw_rem;
      3'b111:  mw_res = mw_remu;
      default: mw_res = '0;
    endcase
  end

  assign ri_sra  = $signed(data_rs1) >>> shamt;
  assign riw_sra = $signed(a_w) >>> shamt[4:0];

  always_comb begin
    case (funct3)
      3'b000:  ri_res = funct7_5 ? data_rs1 - op_b : sum;
      3'b001:  ri_res = data_rs1 << shamt;
      3'b010:  ri_res = {63'b0, $signed(data_rs1) < $signed(op_b)};
      3'b011:  ri_res = {63'b0, data_rs1 < op_b};
      3'b100:  ri_res = data_rs1 ^ op_b;
      3'b101:  ri_res = funct7_5 ? ri_sra : data_rs1 >> shamt;
      3'b110:  ri_res = data_rs1 | op_b;
      default: ri_res = data_rs1 & op_b;
    endcase
    case (funct3)
      3'b000:  riw_res = funct7_5 ? a_w - b_w : sum[31:0];
      3'b001:  riw_res = a_w << shamt[4:0];
      3'b101:  riw_res = funct7_5 ? riw_sra : a_w >> shamt[4:0];
      default: riw_res = '0;
    endcase
  end

  always_comb begin
    case (alu_class)
      addop:   alu_result = sum;
      mop:     alu_result = m_res;
      mwop:    alu_result = sext32(mw_res);
      riop:    alu_result = ri_res;
      riwop:   alu_result = sext32(riw_res);
      default: alu_result = '0; // branch and none write nothing.
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  br_cond = data_rs1 == data_rs2;
      3'b001:  br_cond = data_rs1 != data_rs2;
      3'b100:  br_cond = $signed(data_rs1) < $signed(data_rs2);
      3'b101:  br_cond = $signed(data_rs1) >= $signed(data_rs2);
      3'b110:  br_cond = data_rs1 < data_rs2;
      3'b111:  br_cond = data_rs1 >= data_rs2;
      default: br_cond = 1'b0;
    endcase
  end

  assign br_result = (alu_class == branch) & br_cond;

endmodule

/* hw/rv_regfile.sv */
module rv_regfile
  import rv_exec_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      raddr_a,
  input  logic [4:0]      raddr_b,
  input  logic [4:0]      host_raddr,
  input  logic            wen,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rdata_a,
  output logic [xlen-1:0] rdata_b,
  output logic [xlen-1:0] host_rdata
);

  logic [xlen-1:0] regs [1:31]; // x0 has no storage.

  function automatic logic [xlen-1:0] read_reg(input logic [4:0] addr);
    return (addr == 5'd0) ? '0 : regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a    = read_reg(raddr_a);
  assign rdata_b    = read_reg(raddr_b);
  // host port is only sampled once the pipeline has drained.
  assign host_rdata = read_reg(host_raddr);

endmodule

/* hw/rv_apb_port.sv */
module rv_apb_port
  import rv_exec_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [11:0]     paddr,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [31:0]     pwdata,
  input  logic            busy,
  input  logic [xlen-1:0] pc,
  input  logic [31:0]     br_count,
  input  logic [xlen-1:0] host_rdata,
  output logic [31:0]     prdata,
  output logic            pready,
  output logic            pslverr,
  output logic            issue_valid,
  output logic [31:0]     issue_instr,
  output logic [4:0]      host_raddr
);

  logic access;
  logic hit_instr;
  logic hit_pc_lo;
  logic hit_pc_hi;
  logic hit_count;
  logic hit_gpr;
  logic bad_access;
  logic wr_instr;

  assign access    = psel & penable;
  assign hit_instr = paddr == reg_instr;
  assign hit_pc_lo = paddr == reg_pc_lo;
  assign hit_pc_hi = paddr == reg_pc_hi;
  assign hit_count = paddr == reg_br_count;
  assign hit_gpr   = (paddr[11:8] == reg_gpr_base[11:8]) && (paddr[1:0] == 2'b00);

  // everything except the instruction register is read only.
  assign bad_access = !(hit_instr | hit_pc_lo | hit_pc_hi | hit_count | hit_gpr) |
                      (pwrite ? !hit_instr : hit_instr);

  // reads wait until both stages are empty.
  assign pready   = access & (pwrite | !(busy | issue_valid));
  assign pslverr  = pready & bad_access;
  assign wr_instr = pready & pwrite & !bad_access;

  assign host_raddr = paddr[7:3];

  always_comb begin
    prdata = '0;
    if (hit_pc_lo) prdata = pc[31:0];
    else if (hit_pc_hi) prdata = pc[xlen-1:32];
    else if (hit_count) prdata = br_count;
    else if (hit_gpr) prdata = paddr[2] ? host_rdata[xlen-1:32] : host_rdata[31:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) issue_valid <= 1'b0;
    else issue_valid <= wr_instr;
  end

  always_ff @(posedge clk) begin
    if (wr_instr) issue_instr <= pwdata;
  end

endmodule

/* hw/rv_decode_stage.sv */
module rv_decode_stage
  import rv_exec_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            issue_valid,
  input  logic [31:0]     issue_instr,
  output logic            d_valid,
  output logic            add_pc_en,
  output logic            add_rs1_en,
  output logic            add_zero_en,
  output logic            imm_en,
  output logic            rs2_en,
  output alu_class_e      alu_class,
  output logic [2:0]      funct3,
  output logic            funct7_5,
  output logic [xlen-1:0] imm,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output logic            rd_wen,
  output logic            jal_en,
  output logic            branch_en
);

  rv_opcode_e      opcode;
  alu_class_e      class_d;
  logic [xlen-1:0] imm_i, imm_u, imm_b, imm_j, imm_d;
  logic            pc_d, rs1_d, zero_d, imm_en_d, rs2_d;
  logic            f7_d, wen_d, jal_d, br_d;
  logic            is_mul;
  logic            is_sra;

  assign opcode = rv_opcode_e'(issue_instr[6:0]);
  assign is_mul = issue_instr[31:25] == 7'b0000001;
  // i-type only looks at bit 30 for srai, so addi never turns into a sub.
  assign is_sra = issue_instr[30] & (issue_instr[14:12] == 3'b101);

  assign imm_i = {{52{issue_instr[31]}}, issue_instr[31:20]};
  assign imm_u = {{32{issue_instr[31]}}, issue_instr[31:12], 12'b0};
  assign imm_b = {{51{issue_instr[31]}}, issue_instr[31], issue_instr[7],
                  issue_instr[30:25], issue_instr[11:8], 1'b0};
  assign imm_j = {{43{issue_instr[31]}}, issue_instr[31], issue_instr[19:12],
                  issue_instr[20], issue_instr[30:21], 1'b0};

  always_comb begin
    class_d  = none;
    imm_d    = '0;
    pc_d     = 1'b0;
    rs1_d    = 1'b0;
    zero_d   = 1'b0;
    imm_en_d = 1'b0;
    rs2_d    = 1'b0;
    f7_d     = 1'b0;
    wen_d    = 1'b0;
    jal_d    = 1'b0;
    br_d     = 1'b0;
    case (opcode)
      opc_op, opc_op_32: begin
        if (opcode == opc_op) class_d = is_mul ? mop : riop;
        else class_d = is_mul ? mwop : riwop;
        rs1_d = 1'b1;
        rs2_d = 1'b1;
        f7_d  = issue_instr[30];
        wen_d = 1'b1;
      end
      opc_op_imm, opc_op_imm_32: begin
        class_d  = (opcode == opc_op_imm) ? riop : riwop;
        rs1_d    = 1'b1;
        imm_en_d = 1'b1;
        imm_d    = imm_i;
        f7_d     = is_sra;
        wen_d    = 1'b1;
      end
      opc_lui, opc_auipc: begin
        class_d  = addop;
        zero_d   = opcode == opc_lui;
        pc_d     = opcode == opc_auipc;
        imm_en_d = 1'b1;
        imm_d    = imm_u;
        wen_d    = 1'b1;
      end
      opc_jal: begin
        imm_d = imm_j; // link value is formed in the execute stage.
        jal_d = 1'b1;
        wen_d = 1'b1;
      end
      opc_branch: begin
        class_d = branch;
        rs2_d   = 1'b1;
        imm_d   = imm_b;
        br_d    = 1'b1;
      end
      default: ;
    endcase
    wen_d = wen_d & (issue_instr[11:7] != 5'd0); // x0 is never written.
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) d_valid <= 1'b0;
    else d_valid <= issue_valid;
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      add_pc_en   <= pc_d;
      add_rs1_en  <= rs1_d;
      add_zero_en <= zero_d;
      imm_en      <= imm_en_d;
      rs2_en      <= rs2_d;
      alu_class   <= class_d;
      funct3      <= issue_instr[14:12];
      funct7_5    <= f7_d;
      imm         <= imm_d;
      rs1         <= issue_instr[19:15];
      rs2         <= issue_instr[24:20];
      rd          <= issue_instr[11:7];
      rd_wen      <= wen_d;
      jal_en      <= jal_d;
      branch_en   <= br_d;
    end
  end

endmodule

/* hw/rv_execute_stage.sv */
module rv_execute_stage
  import rv_exec_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            d_valid,
  input  logic            add_pc_en,
  input  logic            add_rs1_en,
  input  logic            add_zero_en,
  input  logic            imm_en,
  input  logic            rs2_en,
  input  alu_class_e      alu_class,
  input  logic [2:0]      funct3,
  input  logic            funct7_5,
  input  logic [xlen-1:0] imm,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            rd_wen,
  input  logic            jal_en,
  input  logic            branch_en,
  input  logic [xlen-1:0] rdata_a,
  input  logic [xlen-1:0] rdata_b,
  output logic [4:0]      raddr_a,
  output logic [4:0]      raddr_b,
  output logic            w_valid,
  output logic [4:0]      w_rd,
  output logic [xlen-1:0] w_data,
  output logic [xlen-1:0] pc,
  output logic [31:0]     br_count,
  output logic            busy
);

  logic [xlen-1:0] data_rs1, data_rs2;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] pc_plus4, pc_target;
  logic            br_result;
  logic            taken;

  assign raddr_a = rs1;
  assign raddr_b = rs2;

  // bypass the result that is still on its way to the register file.
  assign data_rs1 = (w_valid && w_rd == rs1 && w_rd != 5'd0) ? w_data : rdata_a;
  assign data_rs2 = (w_valid && w_rd == rs2 && w_rd != 5'd0) ? w_data : rdata_b;

  alu i_alu (
    .add_pc_en  (add_pc_en),
    .add_rs1_en (add_rs1_en),
    .add_zero_en(add_zero_en),
    .imm_en     (imm_en),
    .rs2_en     (rs2_en),
    .pc         (pc),
    .data_rs1   (data_rs1),
    .imm        (imm),
    .data_rs2   (data_rs2),
    .alu_class  (alu_class),
    .funct7_5   (funct7_5),
    .funct3     (funct3),
    .alu_result (alu_result),
    .br_result  (br_result)
  );

  assign taken     = branch_en & br_result;
  assign pc_plus4  = pc + 64'd4;
  assign pc_target = pc + imm;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_valid  <= 1'b0;
      pc       <= pc_reset;
      br_count <= '0;
    end else begin
      w_valid <= d_valid & rd_wen;
      if (d_valid) pc <= (taken | jal_en) ? pc_target : pc_plus4;
      if (d_valid & taken) br_count <= br_count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (d_valid) begin
      w_rd   <= rd;
      w_data <= jal_en ? pc_plus4 : alu_result; // jal links to the next pc.
    end
  end

  assign busy = d_valid | w_valid;

endmodule

/* hw/rv_exec_top.sv */
module rv_exec_top
  import rv_exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [11:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic            issue_valid, busy;
  logic [31:0]     issue_instr, br_count;
  logic [4:0]      host_raddr;
  logic [xlen-1:0] pc, host_rdata;

  logic            d_valid, add_pc_en, add_rs1_en, add_zero_en, imm_en, rs2_en;
  alu_class_e      alu_class;
  logic [2:0]      funct3;
  logic            funct7_5, rd_wen, jal_en, branch_en;
  logic [xlen-1:0] imm;
  logic [4:0]      rs1, rs2, rd;

  logic [4:0]      raddr_a, raddr_b, w_rd;
  logic [xlen-1:0] rdata_a, rdata_b, w_data;
  logic            w_valid;

  rv_apb_port i_apb_port (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .busy, .pc, .br_count, .host_rdata,
    .prdata, .pready, .pslverr, .issue_valid, .issue_instr, .host_raddr
  );

  rv_decode_stage i_decode (
    .clk, .rst_n, .issue_valid, .issue_instr, .d_valid,
    .add_pc_en, .add_rs1_en, .add_zero_en, .imm_en, .rs2_en,
    .alu_class, .funct3, .funct7_5, .imm, .rs1, .rs2, .rd,
    .rd_wen, .jal_en, .branch_en
  );

  rv_execute_stage i_execute (
    .clk, .rst_n, .d_valid,
    .add_pc_en, .add_rs1_en, .add_zero_en, .imm_en, .rs2_en,
    .alu_class, .funct3, .funct7_5, .imm, .rs1, .rs2, .rd,
    .rd_wen, .jal_en, .branch_en, .rdata_a, .rdata_b,
    .raddr_a, .raddr_b, .w_valid, .w_rd, .w_data, .pc, .br_count, .busy
  );

  rv_regfile i_regfile (
    .clk, .rst_n, .raddr_a, .raddr_b, .host_raddr,
    .wen(w_valid), .waddr(w_rd), .wdata(w_data),
    .rdata_a, .rdata_b, .host_rdata
  );

endmodule

/* bench/rv_exec_assertions.sv */
module rv_exec_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic       psel,
  input logic       penable,
  input logic       pready,
  input logic       pslverr,
  input logic       w_valid,
  input logic [4:0] w_rd
);
  timeunit 1ns;
  timeprecision 100ps;

  a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable) |-> !pready) else $error("pready outside access phase.");

  a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> pready) else $error("pslverr without pready.");

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid |-> w_rd != 5'd0) else $error("writeback targets x0.");

endmodule

bind rv_apb_port rv_exec_assertions i_apb_assert (
  .clk, .rst_n, .psel, .penable, .pready, .pslverr, .w_valid(1'b0), .w_rd(5'd0)
);

bind rv_execute_stage rv_exec_assertions i_exec_assert (
  .clk, .rst_n, .psel(1'b0), .penable(1'b0), .pready(1'b0), .pslverr(1'b0), .w_valid, .w_rd
);

/* bench/tb_rv_exec.sv */
module tb_rv_exec;
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // one entry per transaction of the stimulus file.
  int          kinds[$];
  logic [11:0] addrs[$];
  logic [31:0] wdatas[$];
  logic [31:0] expects[$];

  logic [31:0] lfsr_state;
  int          cycles = 0;
  int          cycle_limit = 1000000;
  int          gap;

  rv_exec_top i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .paddr  (paddr),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1.
  endfunction

  // two lfsr bits give 0 to 3 idle cycles.
  task automatic pick_gap(output int n);
    n = 0;
    repeat (2) begin
      n = n * 2 + int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          k;
    logic [11:0] a;
    logic [31:0] w;
    logic [31:0] e;
    string       line;
    fd = $fopen("bench/rv_exec_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file bench/rv_exec_stimulus.txt");
      $display("Some tests failed");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue; // comment or empty line.
      if ($sscanf(line, "%d %h %h %h", k, a, w, e) == 4) begin
        kinds.push_back(k);
        addrs.push_back(a);
        wdatas.push_back(w);
        expects.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // starts and ends on a falling edge.
  task automatic apb_xfer(input int kind, input logic [11:0] addr,
                          input logic [31:0] wdata, input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    psel    = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwrite  = (kind == 0 || kind == 3);
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    case (kind)
      1: begin
        check_value(32'(err), 32'd0, $sformatf("pslverr of read %h", addr));
        check_value(rdata, expected, $sformatf("read of %h", addr));
      end
      2: check_value(32'(err), 32'd1, $sformatf("pslverr of bad read %h", addr));
      default: check_value(32'(err), 32'd0, $sformatf("pslverr of write %h", addr));
    endcase
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    lfsr_state = 32'he829_8c0b;
    load_stimulus();
    cycle_limit = 40 * kinds.size() + 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    foreach (kinds[i]) begin
      apb_xfer(kinds[i], addrs[i], wdatas[i], expects[i]);
      if (kinds[i] != 3) begin // kind 3 is followed directly by the next write.
        pick_gap(gap);
        repeat (gap) @(negedge clk);
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* bench/rv_exec_stimulus.txt */
# kind addr wdata expected; kind 0 write, 1 read, 2 read expecting pslverr,
# 3 write followed by the next transaction without idle cycles. all values hex.
1 008 00000000 80000000
1 00c 00000000 00000000
1 010 00000000 00000000
1 128 00000000 00000000
3 000 ffb00093 00000000
3 000 00c08113 00000000
0 000 401101b3 00000000
1 108 00000000 fffffffb
1 10c 00000000 ffffffff
1 110 00000000 00000007
1 118 00000000 0000000c
3 000 03c09213 00000000
0 000 40425293 00000000
0 000 0020a333 00000000
0 000 0020b3b3 00000000
0 000 0020c433 00000000
1 120 00000000 00000000
1 124 00000000 b0000000
1 12c 00000000 fb000000
1 130 00000000 00000001
1 138 00000000 00000000
1 140 00000000 fffffffc
0 000 7ffff537 00000000
0 000 00a505bb 00000000
0 000 4045d61b 00000000
0 000 00001697 00000000
1 150 00000000 7ffff000
1 158 00000000 ffffe000
1 15c 00000000 ffffffff
1 160 00000000 fffffe00
1 168 00000000 8000102c
1 16c 00000000 00000000
0 000 02208733 00000000
0 000 022097b3 00000000
0 000 0220b833 00000000
0 000 0220a8b3 00000000
0 000 0220c933 00000000
0 000 0220e9b3 00000000
0 000 02015a33 00000000
0 000 02017ab3 00000000
0 000 fff00b13 00000000
0 000 03fb1b93 00000000
0 000 036bcc33 00000000
0 000 0225ccbb 00000000
0 000 0205fd3b 00000000
1 170 00000000 ffffffdd
1 17c 00000000 ffffffff
1 180 00000000 00000006
1 18c 00000000 ffffffff
1 190 00000000 00000000
1 198 00000000 fffffffb
1 1a4 00000000 ffffffff
1 1a8 00000000 00000007
1 1c0 00000000 00000000
1 1c4 00000000 80000000
1 1c8 00000000 fffffb6e
1 1cc 00000000 ffffffff
1 1d0 00000000 ffffe000
0 000 00108463 00000000
0 000 00209463 00000000
0 000 0020c463 00000000
0 000 0020d463 00000000
0 000 0020e463 00000000
0 000 0020f463 00000000
0 000 00208463 00000000
0 000 01000def 00000000
1 008 00000000 800000a0
1 00c 00000000 00000000
1 010 00000000 00000004
1 1d8 00000000 80000094
2 200 00000000 00000000
2 000 00000000 00000000
1 108 00000000 fffffffb

/* sim.f */
hw/rv_exec_pkg.sv
hw/alu.sv
hw/rv_regfile.sv
hw/rv_apb_port.sv
hw/rv_decode_stage.sv
hw/rv_execute_stage.sv
hw/rv_exec_top.sv
bench/rv_exec_assertions.sv
bench/tb_rv_exec.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_exec
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
